/* sources.f */
verilog/uart_pkg.sv
verilog/uart_fifo.sv
verilog/uart_baud_gen.sv
verilog/uart_regs.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
bench/uart_asserts.sv
bench/uart_tb.sv

/* run.sh */
#!/bin/sh
# build and run uart_tb with verilator, status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module uart_tb -f sources.f -o uart_sim || exit 1
out=$(./obj_dir/uart_sim 2>&1)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* bench/uart_tb.sv */
// uart testbench: register checks, loopback traffic, serial line decode and error injection
`default_nettype none

module uart_tb import uart_pkg::*; ();

  localparam int NUM_CFG   = 9;
  localparam int CHARS_PER = 3;  // characters per table entry

  // table entry {loopback, lcr, divisor}, expected data is the byte masked per lcr
  localparam logic [24:0] CFG_TABLE [NUM_CFG] = '{
    {1'b1, 8'h03, 16'd1},  // 8n1
    {1'b1, 8'h00, 16'd2},  // 5n1
    {1'b1, 8'h1b, 16'd1},  // 8e1
    {1'b1, 8'h0e, 16'd3},  // 7o2
    {1'b1, 8'h1d, 16'd2},  // 6e2
    {1'b0, 8'h03, 16'd2},  // external from here on
    {1'b0, 8'h0a, 16'd1},  // 7o1
    {1'b0, 8'h1f, 16'd3},  // 8e2
    {1'b0, 8'h11, 16'd1}   // 6n1, ep alone has no effect
  };

  logic        clk;
  logic        wb_rst_i;
  uart_addr_t  wb_addr_i;
  uart_byte_t  wb_dat_i;
  uart_byte_t  wb_dat_o;
  logic        wb_we_i;
  logic        wb_re_i;
  logic        srx_pad_i;
  logic        stx_pad_o;
  logic [31:0] lcg_state;
  uart_byte_t  sent_q [$];  // bytes in flight for the overrun run

  uart_top i_dut (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .wb_addr_i (wb_addr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_we_i   (wb_we_i),
    .wb_re_i   (wb_re_i),
    .srx_pad_i (srx_pad_i),
    .stx_pad_o (stx_pad_o)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  ///////////////////////////////////////////////////////////////////////
  // helpers
  ///////////////////////////////////////////////////////////////////////
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic next_byte(output uart_byte_t b);
    lcg_state = lcg_step(lcg_state);
    b = lcg_state[23:16];  // middle bits, better spread
  endtask

  function automatic int data_bits(input uart_byte_t lcr);
    return 5 + int'(lcr[1:0]);
  endfunction

  function automatic uart_byte_t word_mask(input uart_byte_t lcr);
    case (lcr[1:0])
      2'd0:    return 8'h1f;
      2'd1:    return 8'h3f;
      2'd2:    return 8'h7f;
      default: return 8'hff;
    endcase
  endfunction

  // even parity makes the count of ones even
  function automatic logic parity_bit(input uart_byte_t lcr, input uart_byte_t data);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++)
      ones += int'(data[i]);
    if (lcr[UART_LC_EP])
      return (ones % 2) == 1;  // odd count needs one more
    else
      return (ones % 2) == 0;
  endfunction

  function automatic int frame_len(input uart_byte_t lcr);
    return 2 + data_bits(lcr) + int'(lcr[UART_LC_PE]) + int'(lcr[UART_LC_SB]);
  endfunction

  // line bits lsb first: start, data, parity, stops (stops left at 1)
  function automatic logic [11:0] frame_bits(input uart_byte_t lcr, input uart_byte_t data);
    logic [11:0] f;
    int          pos;
    int          i;
    f    = '1;
    f[0] = 1'b0;
    pos  = 1;
    for (i = 0; i < data_bits(lcr); i++) begin
      f[pos] = data[i];
      pos++;
    end
    if (lcr[UART_LC_PE])
      f[pos] = parity_bit(lcr, data);
    return f;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "uart_tb stopped at first error");
  endtask

  task automatic check_eq(input string name, input uart_byte_t got, input uart_byte_t exp);
    assert (got === exp) else
      fail_stop($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  ///////////////////////////////////////////////////////////////////////
  // bus and line tasks
  ///////////////////////////////////////////////////////////////////////
  task automatic bus_write(input uart_addr_t addr, input uart_byte_t data);
    @(negedge clk);
    wb_addr_i = addr;
    wb_dat_i  = data;
    wb_we_i   = 1'b1;
    @(negedge clk);
    wb_we_i   = 1'b0;
  endtask

  // strobed read, pops rbr or clears lsr
  task automatic bus_read(input uart_addr_t addr, output uart_byte_t data);
    @(negedge clk);
    wb_addr_i = addr;
    wb_re_i   = 1'b1;
    #1 data = wb_dat_o;
    @(negedge clk);
    wb_re_i = 1'b0;
    repeat (2) @(negedge clk);  // pop lands one cycle after the strobe
  endtask

  task automatic bus_peek(input uart_addr_t addr, output uart_byte_t data);
    @(negedge clk);
    wb_addr_i = addr;
    #1 data = wb_dat_o;  // no strobe, no side effect
  endtask

  task automatic wait_status(input int bit_idx, input logic value, input int limit);
    uart_byte_t lsr;
    int         n;
    bit         hit;
    hit = 1'b0;
    for (n = 0; n < limit && !hit; n++) begin
      bus_peek(UART_REG_LS, lsr);
      hit = (lsr[bit_idx] == value);
    end
    if (!hit)
      fail_stop($sformatf("timeout waiting for lsr bit %0d to become %0d", bit_idx, value));
  endtask

  task automatic configure(input uart_byte_t lcr, input uart_div_t div, input logic loop);
    bus_write(UART_REG_LC, lcr | 8'h80);  // dlab on
    bus_write(UART_REG_RB_TR, div[7:0]);
    bus_write(UART_REG_IE, div[15:8]);
    bus_write(UART_REG_LC, lcr);
    bus_write(UART_REG_MC, {3'b000, loop, 4'h0});
  endtask

  // watch stx_pad_o and sample each bit near its middle
  task automatic decode_tx(input uart_byte_t lcr, input uart_div_t div, input uart_byte_t exp);
    logic [11:0] f;
    int          bit_clks;
    int          n;
    bit          seen;
    f        = frame_bits(lcr, exp);
    bit_clks = 16 * int'(div);
    seen     = 1'b0;
    for (n = 0; n < 64 * bit_clks && !seen; n++) begin
      @(negedge clk);
      seen = (stx_pad_o == 1'b0);
    end
    if (!seen)
      fail_stop("timeout waiting for a start bit on stx_pad_o");
    repeat (bit_clks / 2) @(negedge clk);
    for (n = 0; n < frame_len(lcr); n++) begin
      check_eq($sformatf("stx_pad_o bit %0d", n), {7'd0, stx_pad_o}, {7'd0, f[n]});
      repeat (bit_clks) @(negedge clk);
    end
  endtask

  task automatic send_frame(input uart_byte_t lcr, input uart_div_t div, input uart_byte_t data,
                            input bit bad_par, input bit bad_stop);
    logic [11:0] f;
    int          stop_pos;
    int          i;
    f        = frame_bits(lcr, data);
    stop_pos = 1 + data_bits(lcr) + int'(lcr[UART_LC_PE]);
    if (bad_par)
      f[stop_pos - 1] = ~f[stop_pos - 1];  // flip parity bit
    if (bad_stop)
      f[stop_pos] = 1'b0;
    for (i = 0; i < frame_len(lcr); i++) begin
      @(negedge clk);
      srx_pad_i = f[i];
      repeat (16 * int'(div) - 1) @(negedge clk);
    end
    @(negedge clk);
    srx_pad_i = 1'b1;  // back to idle
  endtask

  task automatic inject_errors(input uart_byte_t lcr, input uart_div_t div);
    uart_byte_t b;
    uart_byte_t rd;
    int         limit;
    limit = 16 * 14 * int'(div) + 64;
    if (lcr[UART_LC_PE]) begin
      next_byte(b);
      b = b & word_mask(lcr);
      send_frame(lcr, div, b, 1'b1, 1'b0);
      wait_status(UART_LS_DR, 1'b1, limit);
      bus_peek(UART_REG_LS, rd);
      check_eq("lsr error bits", rd & 8'h8c, 8'h84);  // pe + ei
      bus_read(UART_REG_RB_TR, rd);
      check_eq("rbr", rd, b);
    end
    next_byte(b);
    b = b & word_mask(lcr);
    send_frame(lcr, div, b, 1'b0, 1'b1);
    wait_status(UART_LS_DR, 1'b1, limit);
    bus_peek(UART_REG_LS, rd);
    check_eq("lsr error bits", rd & 8'h8c, 8'h88);    // fe + ei
    bus_read(UART_REG_RB_TR, rd);
    check_eq("rbr", rd, b);
  endtask

  ///////////////////////////////////////////////////////////////////////
  // main sequence
  ///////////////////////////////////////////////////////////////////////
  initial begin
    uart_byte_t rd;
    uart_byte_t b;
    uart_byte_t lcr;
    uart_div_t  div;
    logic       loop;
    int         e;
    int         k;
    int         limit;
    wb_rst_i  = 1'b1;
    wb_addr_i = '0;
    wb_dat_i  = '0;
    wb_we_i   = 1'b0;
    wb_re_i   = 1'b0;
    srx_pad_i = 1'b1;
    lcg_state = 32'd6755;
    repeat (8) @(negedge clk);
    wb_rst_i = 1'b0;

    // reset values
    bus_peek(UART_REG_LC, rd);
    check_eq("lcr", rd, 8'h03);
    bus_peek(UART_REG_LS, rd);
    check_eq("lsr", rd, 8'h60);
    check_eq("stx_pad_o", {7'd0, stx_pad_o}, 8'h01);

    // scratch and divisor read back
    bus_write(UART_REG_SR, 8'h5a);
    bus_peek(UART_REG_SR, rd);
    check_eq("scratch", rd, 8'h5a);
    bus_write(UART_REG_LC, 8'h83);
    bus_write(UART_REG_RB_TR, 8'ha5);
    bus_write(UART_REG_IE, 8'h3c);
    bus_peek(UART_REG_RB_TR, rd);
    check_eq("dll", rd, 8'ha5);
    bus_peek(UART_REG_IE, rd);
    check_eq("dlm", rd, 8'h3c);
    bus_write(UART_REG_LC, 8'h03);
    bus_peek(UART_REG_IE, rd);
    check_eq("ier", rd, 8'h00);  // no ier behind dlab clear

    for (e = 0; e < NUM_CFG; e++) begin
      {loop, lcr, div} = CFG_TABLE[e];
      configure(lcr, div, loop);
      limit = 16 * 14 * int'(div) + 64;  // polls per character
      for (k = 0; k < CHARS_PER; k++) begin
        next_byte(b);
        bus_write(UART_REG_RB_TR, b);
        if (loop) begin
          wait_status(UART_LS_TE, 1'b0, limit);  // character under way
          wait_status(UART_LS_DR, 1'b1, limit);
          bus_peek(UART_REG_LS, rd);
          check_eq("lsr error bits", rd & 8'h8c, 8'h00);
          bus_read(UART_REG_RB_TR, rd);
          check_eq("rbr", rd, b & word_mask(lcr));
        end else begin
          decode_tx(lcr, div, b & word_mask(lcr));
        end
        wait_status(UART_LS_TE, 1'b1, limit);
      end
      if (!loop)
        inject_errors(lcr, div);
    end

    // fill the rx fifo, then two more for overrun
    configure(8'h03, 16'd1, 1'b1);
    for (k = 0; k < 16; k++) begin
      next_byte(b);
      sent_q.push_back(b);
      bus_write(UART_REG_RB_TR, b);
    end
    wait_status(UART_LS_TE, 1'b1, 16 * 11 * 16 + 200);
    for (k = 0; k < 2; k++) begin
      next_byte(b);
      bus_write(UART_REG_RB_TR, b);
    end
    wait_status(UART_LS_OE, 1'b1, 2 * 11 * 16 + 200);
    wait_status(UART_LS_TE, 1'b1, 2 * 11 * 16 + 200);
    bus_read(UART_REG_LS, rd);
    check_eq("lsr overrun", rd & 8'h82, 8'h82);
    bus_peek(UART_REG_LS, rd);
    check_eq("lsr overrun after read", rd & 8'h02, 8'h00);
    for (k = 0; k < 16; k++) begin
      bus_read(UART_REG_RB_TR, rd);
      check_eq("rbr", rd, sent_q.pop_front());
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/uart_asserts.sv */
// uart assertions: pad idle in loopback, baud pulse width, rx fifo pops and read data
`default_nettype none

module uart_asserts import uart_pkg::*; (
  input logic        clk,
  input logic        wb_rst_i,
  input logic        loopback,
  input logic        stx_pad_o,
  input logic        baud_en,
  input uart_div_t   dl,
  input logic        dl_wr,
  input logic        rf_pop,
  input uart_count_t rf_count,
  input uart_byte_t  wb_dat_o
);

  a_pad_idle: assert property (@(posedge clk) disable iff (wb_rst_i)
      loopback |-> stx_pad_o)
    else $error("stx_pad_o low while loopback is set");

  // single cycle pulse once the divisor is settled
  a_baud_pulse: assert property (@(posedge clk) disable iff (wb_rst_i)
      baud_en && dl > 16'd1 && !dl_wr && $stable(dl) |=> !baud_en)
    else $error("baud_en high for two cycles with divisor above 1");

  a_pop_nonempty: assert property (@(posedge clk) disable iff (wb_rst_i)
      rf_pop |-> rf_count != '0)
    else $error("rf_pop with an empty rx fifo");

  a_read_known: assert property (@(posedge clk) disable iff (wb_rst_i)
      !$isunknown(wb_dat_o))
    else $error("wb_dat_o has unknown bits");

endmodule

bind uart_top uart_asserts i_asserts (
  .clk       (clk),
  .wb_rst_i  (wb_rst_i),
  .loopback  (loopback),
  .stx_pad_o (stx_pad_o),
  .baud_en   (baud_en),
  .dl        (dl),
  .dl_wr     (dl_wr),
  .rf_pop    (rf_pop),
  .rf_count  (rf_count),
  .wb_dat_o  (wb_dat_o)
);

`default_nettype wire

/* verilog/uart_top.sv */
// uart top level: registers, baud generator, both fifos, transmitter, receiver and loopback
`default_nettype none

module uart_top import uart_pkg::*; (
  input  logic       clk,
  input  logic       wb_rst_i,
  input  uart_addr_t wb_addr_i,
  input  uart_byte_t wb_dat_i,
  output uart_byte_t wb_dat_o,
  input  logic       wb_we_i,
  input  logic       wb_re_i,
  input  logic       srx_pad_i,
  output logic       stx_pad_o
);

  uart_byte_t   lcr;
  logic         loopback;
  uart_div_t    dl;
  logic         dl_wr;
  logic         baud_en;
  // tx path
  logic         tf_push;
  uart_byte_t   tf_data;
  uart_byte_t   tf_head;
  uart_count_t  tf_count;
  logic         tf_pop;
  logic         tx_busy;
  logic         tx_serial;
  // rx path
  logic         rx_serial;
  logic         rf_push;
  uart_rx_rec_t rf_rec;
  uart_rx_rec_t rf_head;
  uart_count_t  rf_count;
  logic         rf_pop;
  logic         rf_overrun;

  ///////////////////////////////////////////////////////////////////////
  // loopback routing
  ///////////////////////////////////////////////////////////////////////
  assign rx_serial = loopback ? tx_serial : srx_pad_i;
  assign stx_pad_o = loopback ? 1'b1 : tx_serial;  // pad parked idle

  uart_regs i_regs (
    .clk          (clk),
    .wb_rst_i     (wb_rst_i),
    .wb_addr_i    (wb_addr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_re_i      (wb_re_i),
    .wb_dat_o     (wb_dat_o),
    .lcr_o        (lcr),
    .loopback_o   (loopback),
    .dl_o         (dl),
    .dl_wr_o      (dl_wr),
    .tf_push_o    (tf_push),
    .tf_data_o    (tf_data),
    .tf_count_i   (tf_count),
    .tx_busy_i    (tx_busy),
    .rf_pop_o     (rf_pop),
    .rf_head_i    (rf_head),
    .rf_count_i   (rf_count),
    .rf_overrun_i (rf_overrun)
  );

  uart_baud_gen i_baud (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .dl_i      (dl),
    .dl_wr_i   (dl_wr),
    .baud_en_o (baud_en)
  );

  uart_fifo #(.WIDTH(8), .DEPTH(UART_FIFO_DEPTH)) i_tx_fifo (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .push_i    (tf_push),
    .data_i    (tf_data),
    .pop_i     (tf_pop),
    .head_o    (tf_head),
    .count_o   (tf_count),
    .overrun_o ()            // full tx fifo just drops the write
  );

  uart_tx i_tx (
    .clk        (clk),
    .wb_rst_i   (wb_rst_i),
    .baud_en_i  (baud_en),
    .lcr_i      (lcr),
    .tf_head_i  (tf_head),
    .tf_count_i (tf_count),
    .tf_pop_o   (tf_pop),
    .busy_o     (tx_busy),
    .serial_o   (tx_serial)
  );

  uart_rx i_rx (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .baud_en_i (baud_en),
    .lcr_i     (lcr),
    .serial_i  (rx_serial),
    .rf_push_o (rf_push),
    .rf_rec_o  (rf_rec)
  );

  uart_fifo #(.WIDTH(UART_REC_W), .DEPTH(UART_FIFO_DEPTH)) i_rx_fifo (
    .clk       (clk),
    .wb_rst_i  (wb_rst_i),
    .push_i    (rf_push),
    .data_i    (rf_rec),
    .pop_i     (rf_pop),
    .head_o    (rf_head),
    .count_o   (rf_count),
    .overrun_o (rf_overrun)
  );

endmodule

`default_nettype wire

/* verilog/uart_rx.sv */
// uart receiver: synchronizes the line, samples mid-bit and pushes records with error flags
`default_nettype none

module uart_rx import uart_pkg::*; (
  input  logic         clk,
  input  logic         wb_rst_i,
  input  logic         baud_en_i,
  input  uart_byte_t   lcr_i,
  input  logic         serial_i,
  output logic         rf_push_o,
  output uart_rx_rec_t rf_rec_o
);

  localparam logic [3:0] OS_LAST = 4'(UART_OVERSAMPLE - 1);
  localparam logic [3:0] OS_MID  = 4'(UART_OVERSAMPLE / 2 - 1);  // 8th tick

  logic [1:0] sync;     // two-flop synchronizer
  logic       rxd;
  logic       rxd_d;
  logic       fall;
  rx_state_t  state;
  logic [3:0] os_cnt;
  logic [2:0] bit_cnt;
  uart_byte_t data;
  logic       pe_err;
  logic       mid;      // middle of a data/parity/stop bit

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      sync  <= 2'b11;
      rxd_d <= 1'b1;
    end else begin
      sync  <= {sync[0], serial_i};
      rxd_d <= rxd;
    end
  end

  assign rxd  = sync[1];
  assign fall = rxd_d & ~rxd;
  assign mid  = baud_en_i && os_cnt == OS_LAST;

  ///////////////////////////////////////////////////////////////////////
  // receiver fsm
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state     <= RX_IDLE;
      os_cnt    <= '0;
      bit_cnt   <= '0;
      rf_push_o <= 1'b0;
    end else begin
      rf_push_o <= 1'b0;
      if (baud_en_i && state != RX_IDLE)
        os_cnt <= os_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          if (fall) begin
            state  <= RX_START;
            os_cnt <= '0;
          end
        end
        RX_START: begin
          if (baud_en_i && os_cnt == OS_MID) begin
            os_cnt  <= '0;                       // realign to bit middle
            bit_cnt <= '0;
            state   <= rxd ? RX_IDLE : RX_DATA;  // glitch, not a start bit
          end
        end
        RX_DATA: begin
          if (mid) begin
            bit_cnt <= bit_cnt + 1'b1;
            if ({1'b0, bit_cnt} == uart_word_len(lcr_i) - 4'd1)
              state <= lcr_i[UART_LC_PE] ? RX_PARITY : RX_STOP;
          end
        end
        RX_PARITY: begin
          if (mid)
            state <= RX_STOP;
        end
        RX_STOP: begin
          if (mid) begin
            rf_push_o <= 1'b1;   // record ready, second stop bit not checked
            state     <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // character datapath
  always_ff @(posedge clk) begin
    if (state == RX_START) begin
      data   <= '0;  // unused high bits stay 0
      pe_err <= 1'b0;
    end else if (mid) begin
      case (state)
        RX_DATA:   data[bit_cnt] <= rxd;
        RX_PARITY: pe_err <= rxd ^ (^data) ^ ~lcr_i[UART_LC_EP];
        RX_STOP:   rf_rec_o <= {~rxd, pe_err, data};  // fe on a low stop bit
        default:   data <= data;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
// uart transmitter: pops the tx fifo head and shifts out start, data, parity and stop bits
`default_nettype none

module uart_tx import uart_pkg::*; (
  input  logic        clk,
  input  logic        wb_rst_i,
  input  logic        baud_en_i,
  input  uart_byte_t  lcr_i,
  input  uart_byte_t  tf_head_i,
  input  uart_count_t tf_count_i,
  output logic        tf_pop_o,
  output logic        busy_o,
  output logic        serial_o
);

  localparam logic [3:0] OS_LAST = 4'(UART_OVERSAMPLE - 1);

  logic [11:0] shreg;      // frame lsb first, idle ones behind it
  logic [3:0]  bits_left;
  logic [3:0]  os_cnt;     // oversample ticks in current bit
  logic [3:0]  wl;
  uart_byte_t  data_m;     // head masked to word length
  logic        par;
  logic [11:0] frame;
  logic [3:0]  nbits;

  assign wl     = uart_word_len(lcr_i);
  assign data_m = tf_head_i & (8'hff >> (2'd3 - lcr_i[1:0]));
  assign par    = lcr_i[UART_LC_EP] ? ^data_m : ~^data_m;  // even / odd

  ///////////////////////////////////////////////////////////////////////
  // frame assembly
  ///////////////////////////////////////////////////////////////////////
  always_comb begin
    frame = {3'b000, data_m, 1'b0} | (12'hfff << (wl + 4'd1));  // stop bits are ones
    if (lcr_i[UART_LC_PE])
      frame[wl + 4'd1] = par;
    nbits = wl + 4'd2 + {3'b000, lcr_i[UART_LC_PE]} + {3'b000, lcr_i[UART_LC_SB]};
  end

  // take a character on a baud tick when idle
  assign tf_pop_o = baud_en_i & ~busy_o & (tf_count_i != '0);

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      shreg     <= '1;  // line idles high
      bits_left <= '0;
      os_cnt    <= '0;
      busy_o    <= 1'b0;
    end else if (tf_pop_o) begin
      shreg     <= frame;
      bits_left <= nbits;
      os_cnt    <= '0;
      busy_o    <= 1'b1;
    end else if (busy_o && baud_en_i) begin
      os_cnt <= os_cnt + 1'b1;
      if (os_cnt == OS_LAST) begin        // bit time over
        shreg     <= {1'b1, shreg[11:1]};
        bits_left <= bits_left - 1'b1;
        if (bits_left == 4'd1)
          busy_o <= 1'b0;                 // last stop bit sent
      end
    end
  end

  assign serial_o = shreg[0];

endmodule

`default_nettype wire

/* verilog/uart_regs.sv */
// uart register file: bus decode, control registers, fifo strobes and line status
`default_nettype none

module uart_regs import uart_pkg::*; (
  input  logic         clk,
  input  logic         wb_rst_i,
  input  uart_addr_t   wb_addr_i,
  input  uart_byte_t   wb_dat_i,
  input  logic         wb_we_i,
  input  logic         wb_re_i,
  output uart_byte_t   wb_dat_o,
  output uart_byte_t   lcr_o,
  output logic         loopback_o,
  output uart_div_t    dl_o,
  output logic         dl_wr_o,
  output logic         tf_push_o,
  output uart_byte_t   tf_data_o,
  input  uart_count_t  tf_count_i,
  input  logic         tx_busy_i,
  output logic         rf_pop_o,
  input  uart_rx_rec_t rf_head_i,
  input  uart_count_t  rf_count_i,
  input  logic         rf_overrun_i
);

  uart_byte_t scratch;
  logic       dlab;
  logic       thr_wr;    // write to thr
  logic       dll_wr;
  logic       dlm_wr;
  logic       re_d;      // last read strobe
  logic       re_rise;
  logic       oe_q;      // sticky overrun
  logic       dr, pe, fe, tfe, te, ei;
  uart_byte_t lsr;

  assign dlab   = lcr_o[UART_LC_DL];
  assign thr_wr = wb_we_i && wb_addr_i == UART_REG_RB_TR && !dlab;
  assign dll_wr = wb_we_i && wb_addr_i == UART_REG_RB_TR && dlab;
  assign dlm_wr = wb_we_i && wb_addr_i == UART_REG_IE && dlab;

  ///////////////////////////////////////////////////////////////////////
  // writable registers
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      lcr_o      <= UART_LCR_RESET;
      loopback_o <= 1'b0;
      dl_o       <= '0;  // baud generator stopped until programmed
      scratch    <= '0;
    end else if (wb_we_i) begin
      case (wb_addr_i)
        UART_REG_LC: lcr_o      <= wb_dat_i;
        UART_REG_MC: loopback_o <= wb_dat_i[UART_MC_LOOP];  // only loop bit kept
        UART_REG_SR: scratch    <= wb_dat_i;
        default: begin
          if (dll_wr) dl_o[7:0]  <= wb_dat_i;
          if (dlm_wr) dl_o[15:8] <= wb_dat_i;
        end
      endcase
    end
  end

  // strobes, one cycle after the bus write
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      tf_push_o <= 1'b0;
      dl_wr_o   <= 1'b0;
    end else begin
      tf_push_o <= thr_wr;
      dl_wr_o   <= dll_wr | dlm_wr;  // restart divisor count
    end
  end

  always_ff @(posedge clk) begin
    if (thr_wr)
      tf_data_o <= wb_dat_i;  // travels with tf_push_o
  end

  ///////////////////////////////////////////////////////////////////////
  // read side effects
  ///////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i)
      re_d <= 1'b0;
    else
      re_d <= wb_re_i;
  end

  assign re_rise = wb_re_i & ~re_d;

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rf_pop_o <= 1'b0;
      oe_q     <= 1'b0;
    end else begin
      // advance rx fifo after the rbr read, never on empty
      rf_pop_o <= re_rise && wb_addr_i == UART_REG_RB_TR && !dlab && rf_count_i != '0;
      if (rf_overrun_i)
        oe_q <= 1'b1;  // a new overrun wins over the clear
      else if (re_rise && wb_addr_i == UART_REG_LS)
        oe_q <= 1'b0;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // line status
  ///////////////////////////////////////////////////////////////////////
  assign dr  = rf_count_i != '0;
  assign pe  = dr & rf_head_i[8];  // head flags only valid with data
  assign fe  = dr & rf_head_i[9];
  assign tfe = tf_count_i == '0;
  assign te  = tfe & ~tx_busy_i;   // shifter drained too
  assign ei  = pe | fe | oe_q;

  always_comb begin
    lsr = '0;
    lsr[UART_LS_DR]  = dr;
    lsr[UART_LS_OE]  = oe_q;
    lsr[UART_LS_PE]  = pe;
    lsr[UART_LS_FE]  = fe;
    lsr[UART_LS_TFE] = tfe;
    lsr[UART_LS_TE]  = te;
    lsr[UART_LS_EI]  = ei;
  end

  // read mux, combinational from the address
  always_comb begin
    case (wb_addr_i)
      UART_REG_RB_TR: wb_dat_o = dlab ? dl_o[7:0] : (dr ? rf_head_i[7:0] : '0);
      UART_REG_IE:    wb_dat_o = dlab ? dl_o[15:8] : '0;
      UART_REG_LC:    wb_dat_o = lcr_o;
      UART_REG_MC:    wb_dat_o = uart_byte_t'(loopback_o) << UART_MC_LOOP;
      UART_REG_LS:    wb_dat_o = lsr;
      UART_REG_SR:    wb_dat_o = scratch;
      default:        wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/uart_baud_gen.sv */
// uart baud generator: divisor latch down-counter giving the 16x oversampling enable
`default_nettype none

module uart_baud_gen import uart_pkg::*; (
  input  logic      clk,
  input  logic      wb_rst_i,
  input  uart_div_t dl_i,
  input  logic      dl_wr_i,
  output logic      baud_en_o
);

  uart_div_t dlc;  // divisor counter

  // preset on divisor write or on reaching zero
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i)
      dlc <= '0;
    else if (dl_wr_i || dlc == '0)
      dlc <= dl_i - 16'd1;
    else
      dlc <= dlc - 16'd1;
  end

  // one pulse per dl clocks, silent with dl == 0
  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i)
      baud_en_o <= 1'b0;
    else
      baud_en_o <= dl_i != '0 && dlc == '0;
  end

endmodule

`default_nettype wire

/* verilog/uart_fifo.sv */
// uart fifo: synchronous circular buffer with visible head, count and overrun pulse
`default_nettype none

module uart_fifo import uart_pkg::*; #(
  parameter int WIDTH = 8,
  parameter int DEPTH = UART_FIFO_DEPTH
) (
  input  logic             clk,
  input  logic             wb_rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] head_o,
  output uart_count_t      count_o,
  output logic             overrun_o
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             empty;
  logic             do_push;
  logic             do_pop;

  assign full    = count_o == uart_count_t'(DEPTH);
  assign empty   = count_o == '0;
  assign do_pop  = pop_i & ~empty;
  assign do_push = push_i & (~full | do_pop);  // slot freed by a pop this cycle
  assign head_o  = mem[rd_ptr];                // head always visible

  always_ff @(posedge clk) begin
    if (do_push)
      mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge clk or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count_o   <= '0;
      overrun_o <= 1'b0;
    end else begin
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;  // none, or both at once
      endcase
      overrun_o <= push_i & ~do_push;  // dropped entry
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_pkg.sv */
// uart package: register map, bit positions, widths and shared types of the uart core
`default_nettype none

package uart_pkg;

  ///////////////////////////////////////////////////////////////////////
  // sizes
  ///////////////////////////////////////////////////////////////////////
  localparam int UART_FIFO_DEPTH = 16;  // entries per direction
  localparam int UART_REC_W      = 10;  // rx record: byte + pe + fe
  localparam int UART_OVERSAMPLE = 16;  // baud enables per bit

  // register addresses
  localparam logic [2:0] UART_REG_RB_TR = 3'd0;  // rbr / thr / dll
  localparam logic [2:0] UART_REG_IE    = 3'd1;  // dlm only, no ier here
  localparam logic [2:0] UART_REG_LC    = 3'd3;
  localparam logic [2:0] UART_REG_MC    = 3'd4;
  localparam logic [2:0] UART_REG_LS    = 3'd5;
  localparam logic [2:0] UART_REG_SR    = 3'd7;

  // line control bits
  localparam int UART_LC_SB = 2;  // two stop bits
  localparam int UART_LC_PE = 3;  // parity enable
  localparam int UART_LC_EP = 4;  // even parity
  localparam int UART_LC_DL = 7;  // divisor latch access

  localparam int UART_MC_LOOP = 4;

  // line status bits
  localparam int UART_LS_DR  = 0;
  localparam int UART_LS_OE  = 1;
  localparam int UART_LS_PE  = 2;
  localparam int UART_LS_FE  = 3;
  localparam int UART_LS_TFE = 5;
  localparam int UART_LS_TE  = 6;
  localparam int UART_LS_EI  = 7;

  localparam logic [7:0] UART_LCR_RESET = 8'h03;  // 8n1

  ///////////////////////////////////////////////////////////////////////
  // types
  ///////////////////////////////////////////////////////////////////////
  typedef logic [7:0]            uart_byte_t;
  typedef logic [2:0]            uart_addr_t;
  typedef logic [15:0]           uart_div_t;
  typedef logic [UART_REC_W-1:0] uart_rx_rec_t;  // {fe, pe, data}
  typedef logic [4:0]            uart_count_t;   // 0..16

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  // data bits per character, 5..8, from lcr[1:0]
  function automatic logic [3:0] uart_word_len(input uart_byte_t lcr);
    return 4'd5 + {2'b00, lcr[1:0]};
  endfunction

endpackage

`default_nettype wire
